// File: ellipse_params.svh
/*
  Ellipse generator parameters.
  Coordinate and arithmetic widths, default credit depth on the
  pixel stream, and the length of the decision-term setup sequence.
*/

`ifndef ELLIPSE_PARAMS_SVH
`define ELLIPSE_PARAMS_SVH

`define ELL_BITS_RES     12  // screen coordinate width
`define ELL_BITS_CORE    24  // decision arithmetic and multiplier width
`define ELL_CREDITS      4   // pixel slots the consumer grants after reset
`define ELL_SETUP_CYCLES 6   // setup_start to setup_done distance

`endif

// File: ellipse_pkg.sv
/*
  Ellipse generator types.
  Coordinates, command, setup geometry, stepping offsets and the
  pixel record shared by the sequencer, datapath and output stage.
*/

`include "ellipse_params.svh"

package ellipse_pkg;

  typedef logic signed [`ELL_BITS_RES-1:0]  coord_t;  // screen coordinate / radius
  typedef logic signed [`ELL_BITS_CORE-1:0] core_t;   // decision term width

  typedef enum logic [1:0] {
    q_pp = 2'd0,  // +x +y
    q_mp = 2'd1,  // bit 0 mirrors x
    q_pm = 2'd2,  // bit 1 mirrors y
    q_mm = 2'd3
  } quadrant_t;

  typedef struct packed {
    quadrant_t quadrant;
    coord_t    xc;       // center
    coord_t    yc;
    coord_t    xr;       // radii, non-negative
    coord_t    yr;
  } ellipse_cmd_t;

  typedef struct packed {
    core_t rx2;  // xr squared in the current half
    core_t ry2;  // yr squared
    core_t p;    // initial decision value
    core_t py;   // initial 2*rx2*y
  } geom_t;

  typedef struct packed {
    coord_t x;  // offset in the stepping frame of the current half
    coord_t y;
  } offset_t;

  typedef struct packed {
    coord_t x;  // absolute screen position
    coord_t y;
  } pixel_t;

endpackage

// File: ellipse_sequencer.sv
/*
  Ellipse command sequencer.
  Latches a command, runs setup and arc stepping for the first half,
  then again with swapped radii for the second half. Raises busy for
  the duration and a single-cycle completion pulse at the end.
*/

module ellipse_sequencer import ellipse_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         run,               // command strobe
  input  ellipse_cmd_t cmd,
  output logic         busy,              // internal busy or a run in flight
  output logic         setup_start,       // one-cycle kick to the setup block
  output offset_t      radii,             // radii in the frame of the current half
  input  logic         setup_done,
  output logic         arc_start,         // one-cycle kick to the stepper
  input  logic         arc_done,
  output logic         half,              // 0 = x-major octant, 1 = swapped axes
  output ellipse_cmd_t cmd_latched,
  output logic         ellipse_complete
);

  typedef enum logic [1:0] {
    st_idle,    // waiting for run
    st_setup,   // multiplier sequence running
    st_arc,     // stepper emitting pixels
    st_finish   // switching to the second half
  } seq_state_t;

  seq_state_t state;
  logic       busy_int;    // command owned, run ignored while high
  logic       accept;
  logic       zero_radii;  // center point only, one half is enough

  assign accept     = run && !busy_int;
  assign busy       = busy_int || run;  // flag right away on run
  assign zero_radii = (cmd_latched.xr == '0) && (cmd_latched.yr == '0);

  // second half walks the other axis, so radii trade places
  always_comb begin
    if (half) begin
      radii = '{x: cmd_latched.yr, y: cmd_latched.xr};
    end else begin
      radii = '{x: cmd_latched.xr, y: cmd_latched.yr};
    end
  end

  always_ff @(posedge clk) begin
    if (accept) cmd_latched <= cmd;  // hold the whole command for both halves
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state            <= st_idle;
      busy_int         <= 1'b0;
      half             <= 1'b0;
      setup_start      <= 1'b0;
      arc_start        <= 1'b0;
      ellipse_complete <= 1'b0;
    end else begin
      setup_start      <= 1'b0;  // all strobes are single cycle
      arc_start        <= 1'b0;
      ellipse_complete <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            busy_int    <= 1'b1;
            half        <= 1'b0;
            setup_start <= 1'b1;  // setup begins the cycle after accept
            state       <= st_setup;
          end
        end
        st_setup: begin
          if (setup_done) begin
            arc_start <= 1'b1;  // geom is valid and held from here
            state     <= st_arc;
          end
        end
        st_arc: begin
          if (arc_done) begin
            if (half || zero_radii) begin
              // arc_done lines up with the last pixel_valid
              ellipse_complete <= 1'b1;
              busy_int         <= 1'b0;
              state            <= st_idle;
            end else begin
              state <= st_finish;
            end
          end
        end
        st_finish: begin
          half        <= 1'b1;  // swaps radii for the rerun
          setup_start <= 1'b1;
          state       <= st_setup;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // setup only answers a start that this FSM issued
  a_no_done_in_idle: assert property (
    @(posedge clk) disable iff (reset) setup_done |-> (state != st_idle)
  );

endmodule

// File: ellipse_setup.sv
/*
  Ellipse setup datapath.
  One registered 24-bit multiplier scheduled over a fixed sequence to
  produce rx2, ry2 and the initial decision terms p and py.
  geom is held until the next setup_start.
*/

`include "ellipse_params.svh"

module ellipse_setup import ellipse_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    setup_start,  // one-cycle start
  input  offset_t radii,        // xr in .x, yr in .y
  output logic    setup_done,   // one-cycle, SETUP_CYCLES after start
  output geom_t   geom
);

  localparam logic [2:0] LAST_STEP = 3'(`ELL_SETUP_CYCLES - 1);

  logic [2:0] step;    // sequence position
  logic       active;
  core_t      mult_a;  // shared multiplier operands
  core_t      mult_b;
  core_t      mult_y;  // product, one cycle behind the operands
  core_t      yr_ext;

  assign yr_ext = core_t'(radii.y);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active     <= 1'b0;
      step       <= '0;
      setup_done <= 1'b0;
    end else begin
      setup_done <= 1'b0;
      if (setup_start) begin
        active <= 1'b1;
        step   <= 3'd1;
      end else if (active) begin
        if (step == LAST_STEP) begin
          active     <= 1'b0;
          setup_done <= 1'b1;  // geom final on this edge
        end else begin
          step <= step + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    mult_y <= mult_a * mult_b;  // low 24 bits are enough for screen radii
    if (setup_start) begin
      mult_a <= core_t'(radii.x);  // xr * xr
      mult_b <= core_t'(radii.x);
    end else if (active) begin
      case (step)
        3'd1: begin
          mult_a <= yr_ext;  // yr * yr
          mult_b <= yr_ext;
        end
        3'd2: begin
          geom.rx2 <= mult_y;
          geom.p   <= (mult_y + core_t'(2)) >>> 2;  // rx2/4 rounded
          mult_a   <= mult_y;                       // rx2 * yr
          mult_b   <= yr_ext;
        end
        3'd3: begin
          geom.ry2 <= mult_y;  // operands held, product stays rx2*yr
        end
        3'd4: begin
          geom.py <= mult_y <<< 1;
        end
        LAST_STEP: begin
          geom.p <= geom.p + geom.ry2 - mult_y;
        end
        default: ;
      endcase
    end
  end

  // a restart mid-sequence would corrupt the shared multiplier schedule
  a_no_overlap: assert property (
    @(posedge clk) disable iff (reset) setup_start |-> !active
  );

endmodule

// File: ellipse_arc_stepper.sv
/*
  Midpoint arc stepper.
  Walks one octant of the quadrant along x, then the flat edge at y = 0
  when the arc ends close to the axis. Only advances while the output
  stage grants a credit.
*/

module ellipse_arc_stepper import ellipse_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    arc_start,   // geom is valid and stepping begins
  input  geom_t   geom,
  input  offset_t radii,       // radii of the current half
  input  logic    credit_ok,   // output stage has a free slot
  output logic    step_valid,
  output offset_t offset,
  output logic    arc_done     // pulses with the last pixel handoff
);

  typedef enum logic [1:0] {
    s_idle,
    s_arc,       // x-major arc
    s_flat_clr,  // one dead cycle to drop y to the axis
    s_flat       // straight run at y = 0
  } step_state_t;

  step_state_t state;
  coord_t      x;
  coord_t      y;
  core_t       p;      // decision value
  core_t       px;     // 2*ry2*x
  core_t       py;     // 2*rx2*y
  logic        p_pos;
  coord_t      x_n;    // values after the current arc pixel
  coord_t      y_n;
  core_t       px_n;
  core_t       py_n;
  core_t       p_n;
  logic        arc_last;
  logic        flat_next;

  assign p_pos     = (p > core_t'(0));
  assign x_n       = x + coord_t'(1);
  assign y_n       = p_pos ? y - coord_t'(1) : y;  // step down when outside the curve
  assign px_n      = px + (geom.ry2 <<< 1);
  assign py_n      = p_pos ? py - (geom.rx2 <<< 1) : py;
  assign p_n       = p_pos ? p + geom.ry2 + px_n - py_n : p + geom.ry2 + px_n;
  assign arc_last  = (px_n > py_n);  // slope passed -1
  assign flat_next = (y_n < coord_t'(2)) && (x_n <= radii.x);

  assign step_valid = credit_ok && ((state == s_arc) || (state == s_flat));
  assign offset     = '{x: x, y: y};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= s_idle;
      arc_done <= 1'b0;
      x        <= '0;
      y        <= '0;
      p        <= '0;
      px       <= '0;
      py       <= '0;
    end else begin
      arc_done <= 1'b0;
      if (arc_start) begin
        x  <= '0;
        y  <= radii.y;
        px <= '0;
        p  <= geom.p;
        py <= geom.py;
        if (radii.x >= coord_t'(2)) begin
          state <= s_arc;
        end else if (radii.y < coord_t'(2)) begin
          state <= s_flat_clr;  // covers the center point too
        end else begin
          state    <= s_idle;   // narrow half with nothing to draw
          arc_done <= 1'b1;
        end
      end else if (credit_ok) begin  // without credit everything holds
        case (state)
          s_arc: begin
            x  <= x_n;
            y  <= y_n;
            px <= px_n;
            py <= py_n;
            p  <= p_n;
            if (arc_last) begin
              if (flat_next) begin
                state <= s_flat_clr;
              end else begin
                state    <= s_idle;  // this was the last pixel
                arc_done <= 1'b1;
              end
            end
          end
          s_flat_clr: begin
            y     <= '0;
            state <= s_flat;
          end
          s_flat: begin
            x <= x_n;
            if (x == radii.x) begin
              state    <= s_idle;
              arc_done <= 1'b1;
            end
          end
          default: state <= s_idle;
        endcase
      end
    end
  end

  // a new walk only starts once the previous one has handed off its last pixel
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (reset) arc_start |-> (state == s_idle)
  );

endmodule

// File: ellipse_pixel_out.sv
/*
  Ellipse pixel output stage.
  Maps stepping offsets to screen space: axis swap for the second half,
  quadrant mirroring, center add. Registers the pixel and keeps the
  credit count that throttles the stepper.
*/

`include "ellipse_params.svh"

module ellipse_pixel_out import ellipse_pkg::*; #(
  parameter int CREDIT_DEPTH = `ELL_CREDITS
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         step_valid,
  input  offset_t      offset,
  input  logic         half,
  input  ellipse_cmd_t cmd_latched,
  input  logic         credit_return,  // consumer freed one slot
  output logic         credit_ok,
  output pixel_t       pixel,
  output logic         pixel_valid
);

  localparam int CNT_W = $clog2(CREDIT_DEPTH + 1);

  logic [CNT_W-1:0] credit_cnt;
  coord_t           ax;  // offsets in screen axes
  coord_t           ay;
  coord_t           dx;  // after mirroring
  coord_t           dy;

  assign ax = half ? offset.y : offset.x;
  assign ay = half ? offset.x : offset.y;
  assign dx = cmd_latched.quadrant[0] ? -ax : ax;
  assign dy = cmd_latched.quadrant[1] ? -ay : ay;

  assign credit_ok = (credit_cnt != '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credit_cnt  <= CNT_W'(CREDIT_DEPTH);  // consumer starts empty
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= step_valid;
      case ({step_valid, credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: ;  // both or neither, count unchanged
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (step_valid) begin
      pixel <= '{x: cmd_latched.xc + dx, y: cmd_latched.yc + dy};
    end
  end

  // consumer must not return more slots than it was given
  a_credit_bound: assert property (
    @(posedge clk) disable iff (reset) credit_cnt <= CNT_W'(CREDIT_DEPTH)
  );

endmodule

// File: ellipse_generator.sv
/*
  Ellipse quadrant generator, top level.
  Sequencer, setup multiplier, midpoint stepper and credited pixel
  output. One command draws one quadrant as a stream of pixels.
*/

`include "ellipse_params.svh"

module ellipse_generator import ellipse_pkg::*; #(
  parameter int CREDIT_DEPTH = `ELL_CREDITS
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         run,
  input  ellipse_cmd_t cmd,
  output logic         busy,
  output pixel_t       pixel,
  output logic         pixel_valid,
  input  logic         credit_return,
  output logic         ellipse_complete
);

  logic         setup_start;
  logic         setup_done;
  logic         arc_start;
  logic         arc_done;
  logic         half;
  logic         credit_ok;
  logic         step_valid;
  offset_t      radii;        // current-half radii
  offset_t      offset;       // stepper to output
  geom_t        geom;         // setup results, held per half
  ellipse_cmd_t cmd_latched;

  ellipse_sequencer i_sequencer (
    .clk              (clk),
    .reset            (reset),
    .run              (run),
    .cmd              (cmd),
    .busy             (busy),
    .setup_start      (setup_start),
    .radii            (radii),
    .setup_done       (setup_done),
    .arc_start        (arc_start),
    .arc_done         (arc_done),
    .half             (half),
    .cmd_latched      (cmd_latched),
    .ellipse_complete (ellipse_complete)
  );

  ellipse_setup i_setup (
    .clk         (clk),
    .reset       (reset),
    .setup_start (setup_start),
    .radii       (radii),
    .setup_done  (setup_done),
    .geom        (geom)
  );

  ellipse_arc_stepper i_arc_stepper (
    .clk        (clk),
    .reset      (reset),
    .arc_start  (arc_start),
    .geom       (geom),
    .radii      (radii),
    .credit_ok  (credit_ok),
    .step_valid (step_valid),
    .offset     (offset),
    .arc_done   (arc_done)
  );

  ellipse_pixel_out #(
    .CREDIT_DEPTH (CREDIT_DEPTH)
  ) i_pixel_out (
    .clk           (clk),
    .reset         (reset),
    .step_valid    (step_valid),
    .offset        (offset),
    .half          (half),
    .cmd_latched   (cmd_latched),
    .credit_return (credit_return),
    .credit_ok     (credit_ok),
    .pixel         (pixel),
    .pixel_valid   (pixel_valid)
  );

endmodule

// File: tb_ellipse_generator.sv
/*
  Testbench for the ellipse quadrant generator.
  Loads commands and expected pixel lists from the trace, drives each
  command, models a consumer that returns credits after random delays,
  and checks every pixel, per-command counts and the completion pulse.
*/

`include "ellipse_params.svh"

module tb_ellipse_generator import ellipse_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CREDIT_DEPTH = `ELL_CREDITS;

  logic         clk = 1'b0;
  logic         reset;
  logic         run;
  ellipse_cmd_t cmd;
  logic         busy;
  pixel_t       pixel;
  logic         pixel_valid;
  logic         credit_return = 1'b0;  // owned by the consumer model
  logic         ellipse_complete;

  ellipse_cmd_t cmd_q[$];          // commands in trace order
  int           exp_x_q[$];        // expected pixels of all commands, in order
  int           exp_y_q[$];
  int           exp_count_q[$];    // pixel count per command
  ellipse_cmd_t stray_cmd;         // pulsed while busy, must never run
  int           seed = 32'h2a58;
  int           mismatch_count = 0;
  int           other_count = 0;
  int           cycle_count = 0;
  int           cycle_limit = 0;
  int           hold_cycles = 80;  // credits withheld right after reset
  int           credit_delay = 0;
  int           owed = 0;          // pixels taken, credit not yet given back
  int           pixels_total = 0;
  int           credits_total = 0;
  int           cmd_pixels = 0;
  int           cmd_idx = 0;       // command whose pixels are arriving
  logic         prev_valid = 1'b0;
  logic         prev_complete = 1'b0;

  always #10 clk = ~clk;  // 20 ns period

  ellipse_generator #(
    .CREDIT_DEPTH (CREDIT_DEPTH)
  ) i_ellipse_generator (
    .clk              (clk),
    .reset            (reset),
    .run              (run),
    .cmd              (cmd),
    .busy             (busy),
    .pixel            (pixel),
    .pixel_valid      (pixel_valid),
    .credit_return    (credit_return),
    .ellipse_complete (ellipse_complete)
  );

  task automatic compare_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d",
               $time, what, actual, expected);
      mismatch_count++;
    end
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    other_count++;
  endtask

  task automatic load_trace(output bit ok);
    int           fd;
    int           n;
    int           q;
    int           xc, yc;
    int           xr, yr;
    int           count;
    string        line;
    ellipse_cmd_t c;
    count = 0;
    fd    = $fopen("ellipse_trace.txt", "r");
    ok    = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          case (line.getc(0))
            "C": begin
              n = $sscanf(line, "C %d %d %d %d %d", q, xc, yc, xr, yr);
              c.quadrant = quadrant_t'(q[1:0]);
              c.xc       = coord_t'(xc);
              c.yc       = coord_t'(yc);
              c.xr       = coord_t'(xr);
              c.yr       = coord_t'(yr);
              cmd_q.push_back(c);
              count = 0;
            end
            "P": begin
              n = $sscanf(line, "P %d %d", xc, yc);
              exp_x_q.push_back(xc);
              exp_y_q.push_back(yc);
              count++;
            end
            "E": exp_count_q.push_back(count);
            default: ;  // comment or blank line
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // consumer side, sampled mid-cycle where DUT outputs are settled
  always @(negedge clk) begin
    if (!reset) begin
      credit_return = 1'b0;
      if (pixel_valid) begin
        pixels_total++;
        cmd_pixels++;
        owed++;
        compare_value(busy, 1, "busy while pixels stream");
        if (exp_x_q.size() == 0) begin
          report_error("pixel arrived with no expected pixel left");
        end else begin
          compare_value(int'($signed(pixel.x)), exp_x_q.pop_front(),
                        $sformatf("cmd %0d pixel %0d x", cmd_idx, cmd_pixels));
          compare_value(int'($signed(pixel.y)), exp_y_q.pop_front(),
                        $sformatf("cmd %0d pixel %0d y", cmd_idx, cmd_pixels));
        end
      end
      if (pixels_total - credits_total > CREDIT_DEPTH) begin
        report_error("more pixels outstanding than credits granted");
      end
      if (ellipse_complete) begin
        compare_value(prev_valid, 1, "pixel_valid on the cycle before ellipse_complete");
        compare_value(busy, 0, "busy together with ellipse_complete");
        if (prev_complete) begin
          report_error("ellipse_complete stayed high for more than one cycle");
        end
        if (cmd_idx < exp_count_q.size()) begin
          compare_value(cmd_pixels, exp_count_q[cmd_idx],
                        $sformatf("pixel count of cmd %0d", cmd_idx));
        end else begin
          report_error("completion pulse with no command pending");
        end
        cmd_pixels = 0;
        cmd_idx++;
        if (cmd_idx == 3) hold_cycles = 40;  // long stall across the next start
      end
      if (hold_cycles > 0) begin
        hold_cycles--;
      end else if (owed > 0) begin
        if (credit_delay > 0) begin
          credit_delay--;
        end else begin
          if (credits_total == 0) begin
            compare_value(pixels_total, CREDIT_DEPTH, "pixels before the first credit");
          end
          credit_return = 1'b1;  // one slot freed
          owed--;
          credits_total++;
          credit_delay = $unsigned($random(seed)) % 4;  // 0 to 3 cycles
        end
      end
      prev_valid    = pixel_valid;
      prev_complete = ellipse_complete;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped finishing commands", cycle_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    bit trace_ok;
    reset     = 1'b1;
    run       = 1'b0;
    cmd       = '0;
    stray_cmd = '0;
    stray_cmd.xr = 12'sd5;  // would add pixels if accepted
    stray_cmd.yr = 12'sd5;
    load_trace(trace_ok);
    if (!trace_ok) begin
      $display("Error: the trace file ellipse_trace.txt could not be opened");
      $display("Result: FAILED");
      $finish;
    end else begin
      cycle_limit = 200 * exp_x_q.size() + 100 * cmd_q.size();
      repeat (4) @(negedge clk);
      reset = 1'b0;
      compare_value(busy, 0, "busy after reset");
      compare_value(pixel_valid, 0, "pixel_valid after reset");
      compare_value(ellipse_complete, 0, "ellipse_complete after reset");
      foreach (cmd_q[i]) begin
        @(negedge clk);
        run = 1'b1;
        cmd = cmd_q[i];
        @(negedge clk);
        run = 1'b0;
        repeat (2) @(negedge clk);
        run = 1'b1;  // second run while busy
        cmd = stray_cmd;
        @(negedge clk);
        run = 1'b0;
        @(negedge clk);
        while (!ellipse_complete) @(negedge clk);
        repeat (2) @(negedge clk);
      end
      repeat (20) @(negedge clk);  // drain credits, catch late extra pixels
      compare_value(exp_x_q.size(), 0, "expected pixels never delivered");
      compare_value(cmd_idx, cmd_q.size(), "completed commands");
      $display("Closing: %0d mismatches, %0d other errors", mismatch_count, other_count);
      if (mismatch_count + other_count == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule

// File: ellipse_trace.txt
# C quadrant xc yc xr yr : command, quadrant 0=pp 1=mp 2=pm 3=mm
# P x y : expected pixel in output order, E : end of the command
C 0 100 50 0 0
P 100 50
E
C 0 200 120 3 2
P 200 122
P 201 122
P 202 122
P 203 120
P 203 120
P 203 121
E
C 1 300 80 4 4
P 300 84
P 299 84
P 298 83
P 297 83
P 296 80
P 296 81
P 297 82
P 297 83
E
C 2 50 60 3 2
P 50 58
P 51 58
P 52 58
P 53 60
P 53 60
P 53 59
E
C 3 500 400 4 4
P 500 396
P 499 396
P 498 397
P 497 397
P 496 400
P 496 399
P 497 398
P 497 397
E
C 3 -20 10 0 0
P -20 10
E

// File: compile.f
+incdir+.
ellipse_pkg.sv
ellipse_sequencer.sv
ellipse_setup.sv
ellipse_arc_stepper.sv
ellipse_pixel_out.sv
ellipse_generator.sv
tb_ellipse_generator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the ellipse generator testbench with Verilator and run it.
# The run counts as passed only when the pass line shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_ellipse_generator \
  -f compile.f \
  -o sim_ellipse

sim_output=$(./obj_dir/sim_ellipse 2>&1) || true
echo "$sim_output"

if grep -qx "Result: PASSED" <<< "$sim_output"; then
  exit 0
fi
echo "simulation did not pass"
exit 1
